//--- Makefile
VERILATOR ?= verilator
TOP       ?= uart_tb
RTL_TOP   ?= uart_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
INC_DIR   ?= include
RTL_SRCS  ?= logic/uart_pkg.sv logic/uart_tx.sv logic/uart_rx.sv \
             logic/uart_regs.sv logic/uart_top.sv
SOURCES   := $(RTL_SRCS) dv/uart_tb.sv $(wildcard $(INC_DIR)/*.svh)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "Simulation passed" $(LOG) || { echo "No pass message in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only $(VFLAGS) +incdir+$(INC_DIR) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/uart_tb.sv
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_tb;

    import uart_pkg::*;

    localparam int NUM_TESTS = 16;

    typedef enum logic [1:0] {
        MODE_LOOP,
        MODE_DRIVE,
        MODE_BADSTOP
    } rx_mode_e;

    // One row of stimulus, with the divisor expected after the clamp
    typedef struct packed {
        logic [15:0] div;
        logic [15:0] exp_div;
        logic [7:0]  data;
        rx_mode_e    mode;
        logic        err_access;
    } test_entry_t;

    logic        clk;
    logic        rst_n;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        tx_o;
    logic        rx_i;
    logic        rx_drv;
    logic        loop_sel;
    test_entry_t tests [NUM_TESTS];
    int          seed = 51;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    int          error_count = 0;
    int          fail_tests = 0;
    int          test_count = 0;

    // The receiver listens either to the transmitter or to the serial driver task
    assign rx_i = loop_sel ? tx_o : rx_drv;

    uart_top uart_top_i (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp),
        .rx_i      (rx_i),
        .tx_o      (tx_o)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            error_count++;
        end
    endtask

    // Setup cycle, then access cycle, with response sampled well before the edge
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata, input logic exp_err,
                                output logic [31:0] rdata);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #10;
        check_value("pready", 32'(apb_rsp.pready), 32'd1);
        check_value("pslverr", 32'(apb_rsp.pslverr), 32'(exp_err));
        rdata = apb_rsp.prdata;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata,
                             input logic exp_err);
        logic [31:0] unused_rdata;
        apb_transfer(1'b1, addr, wdata, exp_err, unused_rdata);
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic exp_err,
                            output logic [31:0] rdata);
        apb_transfer(1'b0, addr, 32'd0, exp_err, rdata);
    endtask

    // Waits for the start bit, then samples every bit at its middle
    task automatic watch_tx_frame(input int div, input logic [7:0] exp);
        logic [7:0] bits;
        @(negedge clk);
        while (tx_o) @(negedge clk);
        repeat (div / 2) @(negedge clk);
        check_value("tx_o start bit", 32'(tx_o), 32'd0);
        for (int i = 0; i < 8; i++) begin
            repeat (div) @(negedge clk);
            bits[i] = tx_o;
        end
        check_value("tx_o data byte", 32'(bits), 32'(exp));
        repeat (div) @(negedge clk);
        check_value("tx_o stop bit", 32'(tx_o), 32'd1);
    endtask

    task automatic send_rx_frame(input int div, input logic [7:0] data, input logic stop);
        logic [9:0] frame;
        frame = {stop, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            rx_drv = frame[i];
            repeat (div - 1) @(negedge clk);
        end
        @(negedge clk);
        rx_drv = 1'b1;
    endtask

    task automatic check_rx_byte(input logic [7:0] exp);
        logic [31:0]  rdata;
        uart_rxdata_t rxd;
        rxd = '0;
        while (!rxd.rx_valid) begin
            apb_read(`UART_OFS_RXDATA, 1'b0, rdata);
            rxd = rdata;
        end
        check_value("RXDATA byte", 32'(rxd.data), 32'(exp));
        apb_read(`UART_OFS_RXDATA, 1'b0, rdata);
        rxd = rdata;
        check_value("RXDATA flag after read", 32'(rxd.rx_valid), 32'd0);
    endtask

    function automatic string mode_name(input rx_mode_e mode);
        case (mode)
            MODE_LOOP:  return "loopback";
            MODE_DRIVE: return "driven rx";
            default:    return "driven rx, bad stop";
        endcase
    endfunction

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (error_count == errs_before) begin
            $display("Test %0d %s: ok", test_count, name);
        end else begin
            fail_tests++;
            $display("Test %0d %s: %0d errors", test_count, name, error_count - errs_before);
        end
    endtask

    task automatic build_table();
        tests[0] = '{16'd16, 16'd16, 8'hA5, MODE_LOOP, 1'b1};
        tests[1] = '{16'd4, 16'd4, 8'h3C, MODE_LOOP, 1'b0};
        tests[2] = '{16'd2, 16'd4, 8'h81, MODE_DRIVE, 1'b1};
        tests[3] = '{16'd5, 16'd5, 8'h7E, MODE_DRIVE, 1'b0};
        tests[4] = '{16'd8, 16'd8, 8'h00, MODE_BADSTOP, 1'b0};
        tests[5] = '{16'd1, 16'd4, 8'hFF, MODE_LOOP, 1'b0};
        tests[6] = '{16'd6, 16'd6, 8'h5A, MODE_BADSTOP, 1'b1};
        tests[7] = '{16'd10, 16'd10, 8'hC3, MODE_DRIVE, 1'b0};
        for (int i = 8; i < NUM_TESTS; i++) begin
            tests[i].div        = 16'(4 + (i % 4) * 3);
            tests[i].exp_div    = tests[i].div;
            tests[i].data       = 8'($random(seed));
            tests[i].mode       = (i % 2 == 1) ? MODE_DRIVE : MODE_LOOP;
            tests[i].err_access = 1'b0;
        end
        for (int i = 0; i < NUM_TESTS; i++) begin
            cycle_limit += 120 * int'(tests[i].exp_div);
        end
        cycle_limit += 200;
    endtask

    task automatic run_entry(input int idx);
        test_entry_t  t;
        logic [31:0]  rdata;
        uart_txdata_t txd;
        uart_rxdata_t rxd;
        int           errs_before;
        t = tests[idx];
        errs_before = error_count;
        loop_sel = (t.mode == MODE_LOOP);
        apb_write(`UART_OFS_CTRL0, 32'(t.div), 1'b0);
        apb_read(`UART_OFS_CTRL0, 1'b0, rdata);
        check_value("CTRL0", rdata, 32'(t.exp_div));
        if (t.err_access) begin
            apb_write(`UART_OFS_RXDATA, 32'h0000_01AA, 1'b1);
            apb_write(8'h10, 32'd7, 1'b1);
            apb_read(8'hF0, 1'b1, rdata);
            apb_read(`UART_OFS_CTRL0, 1'b0, rdata);
            check_value("CTRL0 after bad write", rdata, 32'(t.exp_div));
            apb_read(`UART_OFS_RXDATA, 1'b0, rdata);
            rxd = rdata;
            check_value("RXDATA flag after bad write", 32'(rxd.rx_valid), 32'd0);
        end
        case (t.mode)
            MODE_LOOP: begin
                apb_write(`UART_OFS_TXDATA, 32'(t.data), 1'b0);
                fork
                    watch_tx_frame(int'(t.exp_div), t.data);
                    begin
                        apb_read(`UART_OFS_TXDATA, 1'b0, rdata);
                        txd = rdata;
                        check_value("TXDATA flag in frame", 32'(txd.tx_ready), 32'd0);
                        check_value("TXDATA byte", 32'(txd.data), 32'(t.data));
                    end
                join
                txd = '0;
                while (!txd.tx_ready) begin
                    apb_read(`UART_OFS_TXDATA, 1'b0, rdata);
                    txd = rdata;
                end
                check_rx_byte(t.data);
            end
            MODE_DRIVE: begin
                send_rx_frame(int'(t.exp_div), t.data, 1'b1);
                check_rx_byte(t.data);
            end
            default: begin
                send_rx_frame(int'(t.exp_div), t.data, 1'b0);
                repeat (2 * int'(t.exp_div)) @(negedge clk);
                apb_read(`UART_OFS_RXDATA, 1'b0, rdata);
                rxd = rdata;
                check_value("RXDATA flag after bad stop", 32'(rxd.rx_valid), 32'd0);
            end
        endcase
        loop_sel = 1'b0;
        report_test($sformatf("div %0d byte 0x%02h %s", t.div, t.data, mode_name(t.mode)),
                    errs_before);
    endtask

    initial begin
        int           errs_before;
        logic [31:0]  rdata;
        logic         line_min;
        uart_txdata_t txd;
        uart_rxdata_t rxd;
        clk      = 1'b0;
        rst_n    = 1'b0;
        apb_req  = '0;
        rx_drv   = 1'b1;
        loop_sel = 1'b0;
        build_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        errs_before = error_count;
        check_value("tx_o after reset", 32'(tx_o), 32'd1);
        apb_read(`UART_OFS_CTRL0, 1'b0, rdata);
        check_value("CTRL0 after reset", rdata, 32'(`UART_DIV_RESET));
        apb_read(`UART_OFS_CTRL1, 1'b0, rdata);
        check_value("CTRL1 after reset", rdata, 32'd0);
        apb_read(`UART_OFS_RXDATA, 1'b0, rdata);
        rxd = rdata;
        check_value("RXDATA flag after reset", 32'(rxd.rx_valid), 32'd0);
        apb_read(`UART_OFS_TXDATA, 1'b0, rdata);
        txd = rdata;
        check_value("TXDATA flag after reset", 32'(txd.tx_ready), 32'd0);
        report_test("reset values", errs_before);

        // Engines are still held in reset, so the line must stay idle
        errs_before = error_count;
        apb_write(`UART_OFS_TXDATA, 32'h0000_0096, 1'b0);
        line_min = 1'b1;
        repeat (10 * `UART_DIV_RESET) begin
            @(negedge clk);
            line_min = line_min & tx_o;
        end
        check_value("tx_o while disabled", 32'(line_min), 32'd1);
        apb_write(`UART_OFS_CTRL1, 32'd1, 1'b0);
        apb_read(`UART_OFS_CTRL1, 1'b0, rdata);
        check_value("CTRL1", rdata, 32'd1);
        report_test("soft reset", errs_before);

        for (int i = 0; i < NUM_TESTS; i++) begin
            run_entry(i);
        end

        $display("%0d tests run, %0d failed, %0d checks in error",
                 test_count, fail_tests, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+include
logic/uart_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_regs.sv
logic/uart_top.sv
dv/uart_tb.sv

//--- include/uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// APB address and data widths are fixed by the register map
`define UART_AW 8
`define UART_DW 32

// Byte offsets of the four registers
`define UART_OFS_CTRL0  8'h00
`define UART_OFS_CTRL1  8'h04
`define UART_OFS_TXDATA 8'h08
`define UART_OFS_RXDATA 8'h0C

// Smaller divisor writes are raised to this value
`define UART_DIV_MIN 4

// Bit period in clock cycles after reset
`define UART_DIV_RESET 16

`endif

//--- logic/uart_pkg.sv
`include "uart_defines.svh"

package uart_pkg;

    // Register index as seen on address bits 3:2
    typedef enum logic [1:0] {
        CTRL0  = 2'(`UART_OFS_CTRL0 >> 2),
        CTRL1  = 2'(`UART_OFS_CTRL1 >> 2),
        TXDATA = 2'(`UART_OFS_TXDATA >> 2),
        RXDATA = 2'(`UART_OFS_RXDATA >> 2)
    } uart_reg_e;

    typedef struct packed {
        logic                psel;
        logic                penable;
        logic                pwrite;
        logic [`UART_AW-1:0] paddr;
        logic [`UART_DW-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic                pready;
        logic                pslverr;
        logic [`UART_DW-1:0] prdata;
    } apb_rsp_t;

    // The enable bit holds both serial engines in reset while it is low
    typedef struct packed {
        logic [30:0] rsvd;
        logic        enable;
    } uart_ctrl1_t;

    typedef struct packed {
        logic [22:0] rsvd;
        logic        tx_ready;
        logic [7:0]  data;
    } uart_txdata_t;

    typedef struct packed {
        logic [22:0] rsvd;
        logic        rx_valid;
        logic [7:0]  data;
    } uart_rxdata_t;

    // One byte moving between the register block and a serial engine
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } byte_stream_t;

endpackage

//--- logic/uart_regs.sv
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_regs (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  uart_pkg::apb_req_t     apb_req_i,
    output uart_pkg::apb_rsp_t     apb_rsp_o,
    output logic [`UART_DW-1:0]    baud_div_o,
    output logic                   enable_o,
    output uart_pkg::byte_stream_t tx_stream_o,
    input  logic                   tx_ready_i,
    input  uart_pkg::byte_stream_t rx_stream_i,
    output logic                   rx_ack_o
);

    import uart_pkg::*;

    uart_reg_e    reg_idx;
    logic         access;
    logic         addr_bad;
    logic         wr_ok;
    logic         rd_rx;
    logic         tx_flag;
    logic         tx_load;
    logic         tx_valid;
    logic [7:0]   tx_data;
    uart_ctrl1_t  ctrl1;
    uart_txdata_t txdata;
    uart_rxdata_t rxdata;

    // Only the access cycle of a transfer does anything
    assign access   = apb_req_i.psel & apb_req_i.penable;
    assign reg_idx  = uart_reg_e'(apb_req_i.paddr[3:2]);
    assign addr_bad = apb_req_i.paddr > `UART_OFS_RXDATA;

    // RXDATA is read-only so a write there is dropped like an unmapped one
    assign wr_ok = access & apb_req_i.pwrite & !addr_bad & (reg_idx != RXDATA);
    assign rd_rx = access & !apb_req_i.pwrite & !addr_bad & (reg_idx == RXDATA);

    // A byte still waiting for the transmitter keeps the flag low
    assign tx_flag = tx_ready_i & !tx_valid;
    assign tx_load = wr_ok & (reg_idx == TXDATA) & tx_flag;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            baud_div_o <= `UART_DW'(`UART_DIV_RESET);
            enable_o   <= 1'b0;
        end else if (wr_ok) begin
            if (reg_idx == CTRL0) begin
                if (apb_req_i.pwdata < `UART_DW'(`UART_DIV_MIN)) begin
                    baud_div_o <= `UART_DW'(`UART_DIV_MIN);
                end else begin
                    baud_div_o <= apb_req_i.pwdata;
                end
            end
            if (reg_idx == CTRL1) begin
                enable_o <= apb_req_i.pwdata[0];
            end
        end
    end

    // Valid drops once the transmitter takes the byte or the engines are disabled
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_valid <= 1'b0;
        end else if (!enable_o) begin
            tx_valid <= 1'b0;
        end else if (tx_load) begin
            tx_valid <= 1'b1;
        end else if (tx_ready_i) begin
            tx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (tx_load) begin
            tx_data <= apb_req_i.pwdata[7:0];
        end
    end

    assign tx_stream_o.valid = tx_valid;
    assign tx_stream_o.data  = tx_data;

    // The receiver clears its valid flag on the edge after this pulse
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_ack_o <= 1'b0;
        end else begin
            rx_ack_o <= rd_rx & rx_stream_i.valid;
        end
    end

    always_comb begin
        ctrl1           = '0;
        ctrl1.enable    = enable_o;
        txdata          = '0;
        txdata.tx_ready = tx_flag;
        txdata.data     = tx_data;
        rxdata          = '0;
        rxdata.rx_valid = rx_stream_i.valid;
        rxdata.data     = rx_stream_i.data;
    end

    // No wait states, read data straight from the register views
    always_comb begin
        apb_rsp_o.pready  = 1'b1;
        apb_rsp_o.pslverr = access & (addr_bad | (apb_req_i.pwrite & (reg_idx == RXDATA)));
        apb_rsp_o.prdata  = '0;
        if (!addr_bad) begin
            case (reg_idx)
                CTRL0:   apb_rsp_o.prdata = baud_div_o;
                CTRL1:   apb_rsp_o.prdata = ctrl1;
                TXDATA:  apb_rsp_o.prdata = txdata;
                RXDATA:  apb_rsp_o.prdata = rxdata;
                default: apb_rsp_o.prdata = '0;
            endcase
        end
    end

endmodule

//--- logic/uart_rx.sv
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_rx (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic [`UART_DW-1:0]    baud_div_i,
    input  logic                   rx_i,
    output uart_pkg::byte_stream_t rx_stream_o,
    input  logic                   rx_ack_i
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e           state;
    logic                rx_meta;
    logic                rx_sync;
    logic                rx_prev;
    logic [`UART_DW-1:0] baud_cnt;
    logic [2:0]          bit_idx;
    logic [7:0]          shift;
    logic [7:0]          data_q;
    logic                valid_q;
    logic                fall;
    logic                half_end;
    logic                bit_end;
    logic                frame_ok;

    // The line idles high, so the synchronizer resets to 1
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign fall     = rx_prev & !rx_sync;
    assign half_end = baud_cnt == (baud_div_i >> 1) - 1'b1;
    assign bit_end  = baud_cnt == baud_div_i - 1'b1;
    assign frame_ok = (state == RX_STOP) & bit_end & rx_sync;

    // After the start bit is confirmed at mid-bit every later sample lands mid-bit too
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state    <= RX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    bit_idx  <= '0;
                    if (fall) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    baud_cnt <= half_end ? '0 : baud_cnt + 1'b1;
                    if (half_end) begin
                        // A glitch shorter than half a bit is not a start bit
                        state <= rx_sync ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
                    if (bit_end) begin
                        state <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == RX_DATA && bit_end) begin
            shift <= {rx_sync, shift[7:1]};
        end
        if (frame_ok) begin
            data_q <= shift;
        end
    end

    // A new good frame wins over an acknowledge on the same edge
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (frame_ok) begin
            valid_q <= 1'b1;
        end else if (rx_ack_i) begin
            valid_q <= 1'b0;
        end
    end

    assign rx_stream_o.valid = valid_q;
    assign rx_stream_o.data  = data_q;

endmodule

//--- logic/uart_top.sv
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_top (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  uart_pkg::apb_req_t apb_req_i,
    output uart_pkg::apb_rsp_t apb_rsp_o,
    input  logic               rx_i,
    output logic               tx_o
);

    import uart_pkg::*;

    logic [`UART_DW-1:0] baud_div;
    logic                enable;
    logic                eng_rst_n;
    logic                tx_ready;
    logic                rx_ack;
    byte_stream_t        tx_stream;
    byte_stream_t        rx_stream;

    // Engines stay in reset until software sets the CTRL1 enable bit
    assign eng_rst_n = rst_n_i & enable;

    uart_regs uart_regs_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .apb_req_i   (apb_req_i),
        .apb_rsp_o   (apb_rsp_o),
        .baud_div_o  (baud_div),
        .enable_o    (enable),
        .tx_stream_o (tx_stream),
        .tx_ready_i  (tx_ready),
        .rx_stream_i (rx_stream),
        .rx_ack_o    (rx_ack)
    );

    uart_tx uart_tx_i (
        .clk_i       (clk_i),
        .rst_n_i     (eng_rst_n),
        .baud_div_i  (baud_div),
        .tx_stream_i (tx_stream),
        .tx_ready_o  (tx_ready),
        .tx_o        (tx_o)
    );

    uart_rx uart_rx_i (
        .clk_i       (clk_i),
        .rst_n_i     (eng_rst_n),
        .baud_div_i  (baud_div),
        .rx_i        (rx_i),
        .rx_stream_o (rx_stream),
        .rx_ack_i    (rx_ack)
    );

endmodule

//--- logic/uart_tx.sv
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_tx (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic [`UART_DW-1:0]    baud_div_i,
    input  uart_pkg::byte_stream_t tx_stream_i,
    output logic                   tx_ready_o,
    output logic                   tx_o
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    tx_state_e           state;
    logic [`UART_DW-1:0] baud_cnt;
    logic [2:0]          bit_idx;
    logic [7:0]          shift;
    logic                bit_end;
    logic                accept;

    // Last cycle of the current bit period
    assign bit_end = baud_cnt == baud_div_i - 1'b1;
    assign accept  = tx_ready_o & tx_stream_i.valid;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state      <= TX_IDLE;
            baud_cnt   <= '0;
            bit_idx    <= '0;
            tx_ready_o <= 1'b0;
            tx_o       <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    baud_cnt <= '0;
                    bit_idx  <= '0;
                    if (accept) begin
                        state      <= TX_START;
                        tx_ready_o <= 1'b0;
                        tx_o       <= 1'b0;
                    end else begin
                        tx_ready_o <= 1'b1;
                    end
                end
                TX_START: begin
                    baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
                    if (bit_end) begin
                        state <= TX_DATA;
                        tx_o  <= shift[0];
                    end
                end
                TX_DATA: begin
                    baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= TX_STOP;
                            tx_o  <= 1'b1;
                        end else begin
                            tx_o <= shift[1];
                        end
                    end
                end
                TX_STOP: begin
                    baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
                    // Ready again as soon as the stop bit has run its full period
                    if (bit_end) begin
                        state      <= TX_IDLE;
                        tx_ready_o <= 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // LSB first, so the byte moves right one place per data bit
    always_ff @(posedge clk_i) begin
        if (accept) begin
            shift <= tx_stream_i.data;
        end else if (state == TX_DATA && bit_end) begin
            shift <= shift >> 1;
        end
    end

endmodule
